/* core_settings.svh */
// Core-wide width, register count and reset vector macros, included by the package and the RTL
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width, one word per value
`define XLEN 32

// Architectural registers, 5-bit indices
`define NREGS 32

// First fetch address after reset
`define RESET_PC 0

`endif

/* core_pkg.sv */
// Opcode and ALU encodings plus the two-view instruction word, imported by the core stages
`include "core_settings.svh"

package core_pkg;

    // Major opcode in bits 31:26
    typedef enum logic [5:0] {
        OP_ALU  = 6'h00,
        OP_ADDI = 6'h01,
        OP_LW   = 6'h02,
        OP_SW   = 6'h03,
        OP_BEQ  = 6'h04,
        OP_BNE  = 6'h05,
        OP_HALT = 6'h3f
    } opcode_t;

    // Function field of register-register ops
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4
    } alu_op_t;

    // One word, read as register format or immediate format
    typedef union packed {
        struct packed {
            opcode_t                    opcode;
            logic [$clog2(`NREGS)-1:0]  rd;
            logic [$clog2(`NREGS)-1:0]  rs1;
            logic [$clog2(`NREGS)-1:0]  rs2;
            alu_op_t                    funct;
            logic [7:0]                 pad;
        } r_fmt;
        struct packed {
            opcode_t                    opcode;
            logic [$clog2(`NREGS)-1:0]  rd;
            logic [$clog2(`NREGS)-1:0]  rs1;
            logic signed [15:0]         imm;
        } i_fmt;
    } instr_t;

endpackage

/* fetch_unit.sv */
// Program counter and instruction request feeding the fetch/dispatch latch
`include "core_settings.svh"

module fetch_unit (
    input  logic              CLK,
    input  logic              nrst,
    input  logic              ihit,
    input  logic [`XLEN-1:0]  imem_load,
    input  logic              halted,
    input  logic              freeze,
    input  logic              flush,
    input  logic              mem_stall,
    input  logic [`XLEN-1:0]  redirect_pc,
    output logic [`XLEN-1:0]  imem_addr,
    output logic              imem_ren,
    output core_pkg::instr_t  fd_instr,
    output logic [`XLEN-1:0]  fd_pc,
    output logic              fd_valid
);
    logic [`XLEN-1:0] pc;
    logic             take;

    assign imem_addr = pc;
    assign imem_ren  = !halted;

    // Dispatch consumes whatever sits in the latch this cycle
    assign take = !freeze && !mem_stall;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc       <= `XLEN'(`RESET_PC);
            fd_valid <= 1'b0;
        end else if (flush) begin
            pc       <= redirect_pc;
            fd_valid <= 1'b0;
        end else if (take) begin
            fd_valid <= ihit;
            if (ihit) begin
                pc <= pc + `XLEN'(4);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!flush && take && ihit) begin
            fd_instr <= imem_load;
            fd_pc    <= pc;
        end
    end

endmodule

/* reg_file.sv */
// Two-read, one-write register file used by dispatch for operand fetch
`include "core_settings.svh"

module reg_file (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic [$clog2(`NREGS)-1:0]  rs1_addr,
    input  logic [$clog2(`NREGS)-1:0]  rs2_addr,
    output logic [`XLEN-1:0]           rs1_data,
    output logic [`XLEN-1:0]           rs2_data,
    input  logic                       wr_en,
    input  logic [$clog2(`NREGS)-1:0]  wr_addr,
    input  logic [`XLEN-1:0]           wr_data
);
    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Writeback in the same cycle passes straight to the readers
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

/* dispatch_unit.sv */
// Decode, scoreboard hazard check and operand read feeding the dispatch/execute latch
`include "core_settings.svh"

module dispatch_unit (
    input  logic                       CLK,
    input  logic                       nrst,
    input  core_pkg::instr_t           fd_instr,
    input  logic [`XLEN-1:0]           fd_pc,
    input  logic                       fd_valid,
    input  logic                       flush,
    input  logic                       mem_stall,
    input  logic                       wr_en,
    input  logic [$clog2(`NREGS)-1:0]  wr_addr,
    input  logic [`XLEN-1:0]           wr_data,
    output logic                       freeze,
    output logic                       de_valid,
    output core_pkg::opcode_t          de_opcode,
    output core_pkg::alu_op_t          de_alu_op,
    output logic [$clog2(`NREGS)-1:0]  de_rd,
    output logic [`XLEN-1:0]           de_a,
    output logic [`XLEN-1:0]           de_b,
    output logic [`XLEN-1:0]           de_store,
    output logic [`XLEN-1:0]           de_imm,
    output logic [`XLEN-1:0]           de_pc
);
    import core_pkg::*;

    opcode_t                    op;
    logic [$clog2(`NREGS)-1:0]  rs1;
    logic [$clog2(`NREGS)-1:0]  rs2;
    logic [$clog2(`NREGS)-1:0]  rd;
    logic [$clog2(`NREGS)-1:0]  b_addr;
    logic [`XLEN-1:0]           imm_ext;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    logic                       is_r;
    logic                       reads_a;
    logic                       reads_b;
    logic                       writes_rd;
    logic                       a_busy;
    logic                       b_busy;
    logic                       d_busy;
    logic                       hazard;
    logic                       advance;
    logic                       halt_seen;
    logic [`NREGS-1:0]          pending;

    // Opcode sits in the same bits in both views
    assign op      = fd_instr.r_fmt.opcode;
    assign is_r    = (op == OP_ALU);
    assign rd      = fd_instr.i_fmt.rd;
    assign rs1     = fd_instr.i_fmt.rs1;
    assign rs2     = fd_instr.r_fmt.rs2;
    assign imm_ext = {{(`XLEN-16){fd_instr.i_fmt.imm[15]}}, fd_instr.i_fmt.imm};

    // SW and branches read rd through the second port
    assign b_addr    = is_r ? rs2 : rd;
    assign reads_a   = (op != OP_HALT);
    assign reads_b   = is_r || op == OP_SW || op == OP_BEQ || op == OP_BNE;
    assign writes_rd = (is_r || op == OP_ADDI || op == OP_LW) && rd != '0;

    // A register released this cycle is already visible through the file
    assign a_busy = pending[rs1] && !(wr_en && wr_addr == rs1);
    assign b_busy = pending[b_addr] && !(wr_en && wr_addr == b_addr);
    assign d_busy = pending[rd] && !(wr_en && wr_addr == rd);

    assign hazard  = (reads_a && a_busy) || (reads_b && b_busy) || (writes_rd && d_busy);
    assign advance = fd_valid && !hazard && !flush && !mem_stall && !halt_seen;
    // Nothing dispatches once HALT has gone down the pipe
    assign freeze  = (fd_valid && hazard) || mem_stall || halt_seen;

    reg_file reg_file_i (
        .CLK      (CLK),
        .nrst     (nrst),
        .rs1_addr (rs1),
        .rs2_addr (b_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pending   <= '0;
            halt_seen <= 1'b0;
            de_valid  <= 1'b0;
        end else begin
            if (wr_en) begin
                pending[wr_addr] <= 1'b0;
            end
            // A new producer wins over a release of the same register
            if (advance && writes_rd) begin
                pending[rd] <= 1'b1;
            end
            if (advance && op == OP_HALT) begin
                halt_seen <= 1'b1;
            end
            if (!mem_stall) begin
                de_valid <= advance;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (advance) begin
            de_opcode <= op;
            de_alu_op <= fd_instr.r_fmt.funct;
            de_rd     <= rd;
            de_a      <= rs1_data;
            de_b      <= is_r ? rs2_data : imm_ext;
            de_store  <= rs2_data;
            de_imm    <= imm_ext;
            de_pc     <= fd_pc;
        end
    end

endmodule

/* execute_unit.sv */
// ALU and branch resolution, feeding the execute/memory latch and the fetch redirect
`include "core_settings.svh"

module execute_unit (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic                       de_valid,
    input  core_pkg::opcode_t          de_opcode,
    input  core_pkg::alu_op_t          de_alu_op,
    input  logic [$clog2(`NREGS)-1:0]  de_rd,
    input  logic [`XLEN-1:0]           de_a,
    input  logic [`XLEN-1:0]           de_b,
    input  logic [`XLEN-1:0]           de_store,
    input  logic [`XLEN-1:0]           de_imm,
    input  logic [`XLEN-1:0]           de_pc,
    input  logic                       mem_stall,
    output logic                       flush,
    output logic [`XLEN-1:0]           redirect_pc,
    output logic                       em_valid,
    output core_pkg::opcode_t          em_opcode,
    output logic [$clog2(`NREGS)-1:0]  em_rd,
    output logic [`XLEN-1:0]           em_result,
    output logic [`XLEN-1:0]           em_store
);
    import core_pkg::*;

    alu_op_t          op_sel;
    logic [`XLEN-1:0] alu_out;
    logic             is_branch;
    logic             taken;
    logic             writes_rd;

    // ADDI, LW and SW reuse the adder with the immediate as operand b
    assign op_sel = (de_opcode == OP_ALU) ? de_alu_op : ADD;

    always_comb begin
        case (op_sel)
            ADD:     alu_out = de_a + de_b;
            SUB:     alu_out = de_a - de_b;
            AND:     alu_out = de_a & de_b;
            OR:      alu_out = de_a | de_b;
            XOR:     alu_out = de_a ^ de_b;
            default: alu_out = de_a + de_b;
        endcase
    end

    // rd value rides in the store data slot for compares
    assign is_branch   = (de_opcode == OP_BEQ) || (de_opcode == OP_BNE);
    assign taken       = (de_opcode == OP_BEQ) ? (de_a == de_store) : (de_a != de_store);
    assign flush       = de_valid && is_branch && taken && !mem_stall;
    assign redirect_pc = de_pc + (de_imm << 2);

    // Branch, store and halt entries leave with rd 0
    assign writes_rd = (de_opcode == OP_ALU) || (de_opcode == OP_ADDI) || (de_opcode == OP_LW);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            em_valid <= 1'b0;
        end else if (!mem_stall) begin
            em_valid <= de_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!mem_stall) begin
            em_opcode <= de_opcode;
            em_rd     <= writes_rd ? de_rd : '0;
            em_result <= alu_out;
            em_store  <= de_store;
        end
    end

endmodule

/* mem_writeback_unit.sv */
// Data port access, register writeback, scoreboard release and the sticky halt flag
`include "core_settings.svh"

module mem_writeback_unit (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic                       em_valid,
    input  core_pkg::opcode_t          em_opcode,
    input  logic [$clog2(`NREGS)-1:0]  em_rd,
    input  logic [`XLEN-1:0]           em_result,
    input  logic [`XLEN-1:0]           em_store,
    input  logic [`XLEN-1:0]           dmem_load,
    input  logic                       dhit,
    output logic [`XLEN-1:0]           dmem_addr,
    output logic                       dmem_ren,
    output logic                       dmem_wen,
    output logic [`XLEN-1:0]           dmem_store,
    output logic                       mem_stall,
    output logic                       wr_en,
    output logic [$clog2(`NREGS)-1:0]  wr_addr,
    output logic [`XLEN-1:0]           wr_data,
    output logic                       halted
);
    import core_pkg::*;

    logic is_load;
    logic is_store;

    assign is_load  = em_valid && (em_opcode == OP_LW);
    assign is_store = em_valid && (em_opcode == OP_SW);

    // Request level holds from the latch until dhit lets the pipe move
    assign dmem_addr  = em_result;
    assign dmem_store = em_store;
    assign dmem_ren   = is_load;
    assign dmem_wen   = is_store;
    assign mem_stall  = (is_load || is_store) && !dhit;

    // Also serves as the scoreboard release
    assign wr_en   = em_valid && (em_rd != '0) && !mem_stall;
    assign wr_addr = em_rd;
    assign wr_data = is_load ? dmem_load : em_result;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halted <= 1'b0;
        end else if (em_valid && em_opcode == OP_HALT) begin
            halted <= 1'b1;
        end
    end

endmodule

/* core_top.sv */
// Core top level joining the four stages to the instruction and data memory ports
`include "core_settings.svh"

module core_top (
    input  logic              CLK,
    input  logic              nrst,
    output logic [`XLEN-1:0]  imem_addr,
    output logic              imem_ren,
    input  logic [`XLEN-1:0]  imem_load,
    input  logic              ihit,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic              dmem_ren,
    output logic              dmem_wen,
    output logic [`XLEN-1:0]  dmem_store,
    input  logic [`XLEN-1:0]  dmem_load,
    input  logic              dhit,
    output logic              halt
);
    import core_pkg::*;

    instr_t                     fd_instr;
    logic [`XLEN-1:0]           fd_pc;
    logic                       fd_valid;
    logic                       freeze;
    logic                       flush;
    logic [`XLEN-1:0]           redirect_pc;
    logic                       mem_stall;
    logic                       de_valid;
    opcode_t                    de_opcode;
    alu_op_t                    de_alu_op;
    logic [$clog2(`NREGS)-1:0]  de_rd;
    logic [`XLEN-1:0]           de_a;
    logic [`XLEN-1:0]           de_b;
    logic [`XLEN-1:0]           de_store;
    logic [`XLEN-1:0]           de_imm;
    logic [`XLEN-1:0]           de_pc;
    logic                       em_valid;
    opcode_t                    em_opcode;
    logic [$clog2(`NREGS)-1:0]  em_rd;
    logic [`XLEN-1:0]           em_result;
    logic [`XLEN-1:0]           em_store;
    logic                       wr_en;
    logic [$clog2(`NREGS)-1:0]  wr_addr;
    logic [`XLEN-1:0]           wr_data;

    fetch_unit fetch_unit_i (
        .CLK         (CLK),
        .nrst        (nrst),
        .ihit        (ihit),
        .imem_load   (imem_load),
        .halted      (halt),
        .freeze      (freeze),
        .flush       (flush),
        .mem_stall   (mem_stall),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_ren    (imem_ren),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .fd_valid    (fd_valid)
    );

    dispatch_unit dispatch_unit_i (
        .CLK       (CLK),
        .nrst      (nrst),
        .fd_instr  (fd_instr),
        .fd_pc     (fd_pc),
        .fd_valid  (fd_valid),
        .flush     (flush),
        .mem_stall (mem_stall),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .freeze    (freeze),
        .de_valid  (de_valid),
        .de_opcode (de_opcode),
        .de_alu_op (de_alu_op),
        .de_rd     (de_rd),
        .de_a      (de_a),
        .de_b      (de_b),
        .de_store  (de_store),
        .de_imm    (de_imm),
        .de_pc     (de_pc)
    );

    execute_unit execute_unit_i (
        .CLK         (CLK),
        .nrst        (nrst),
        .de_valid    (de_valid),
        .de_opcode   (de_opcode),
        .de_alu_op   (de_alu_op),
        .de_rd       (de_rd),
        .de_a        (de_a),
        .de_b        (de_b),
        .de_store    (de_store),
        .de_imm      (de_imm),
        .de_pc       (de_pc),
        .mem_stall   (mem_stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .em_valid    (em_valid),
        .em_opcode   (em_opcode),
        .em_rd       (em_rd),
        .em_result   (em_result),
        .em_store    (em_store)
    );

    mem_writeback_unit mem_writeback_unit_i (
        .CLK        (CLK),
        .nrst       (nrst),
        .em_valid   (em_valid),
        .em_opcode  (em_opcode),
        .em_rd      (em_rd),
        .em_result  (em_result),
        .em_store   (em_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_store (dmem_store),
        .mem_stall  (mem_stall),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .halted     (halt)
    );

endmodule

/* tb_mem_model.sv */
// Testbench memory responder for the core's instruction and data ports with random hit delays
`include "core_settings.svh"

module tb_mem_model (
    input  logic              CLK,
    input  logic              nrst,
    input  logic [`XLEN-1:0]  imem_addr,
    input  logic              imem_ren,
    output logic [`XLEN-1:0]  imem_load,
    output logic              ihit,
    input  logic [`XLEN-1:0]  dmem_addr,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic [`XLEN-1:0]  dmem_store,
    output logic [`XLEN-1:0]  dmem_load,
    output logic              dhit
);
    timeunit 1ns;
    timeprecision 100ps;

    // Word arrays, loaded by the testbench through hierarchy
    logic [`XLEN-1:0] imem [64];
    logic [`XLEN-1:0] dmem [64];

    logic [15:0]      lfsr = 16'd44672;
    logic [`XLEN-1:0] last_iaddr = '0;
    int               i_wait = 0;
    int               d_wait = 0;
    logic             d_active = 1'b0;
    logic             d_prev_active = 1'b0;

    initial begin
        ihit      = 1'b0;
        dhit      = 1'b0;
        imem_load = '0;
        dmem_load = '0;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    // Two bits give a hit delay of 0 to 3 cycles
    function int next_delay();
        int d;
        d = 0;
        for (int b = 0; b < 2; b++) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return d;
    endfunction

    always @(posedge CLK) begin
        #2;
        if (!nrst) begin
            ihit          = 1'b0;
            dhit          = 1'b0;
            i_wait        = 0;
            d_wait        = 0;
            d_prev_active = 1'b0;
            last_iaddr    = imem_addr;
        end else begin
            // New fetch request after a hit or an address change
            if (ihit || imem_addr != last_iaddr) begin
                i_wait = next_delay();
            end else if (i_wait != 0) begin
                i_wait--;
            end
            ihit       = imem_ren && (i_wait == 0);
            imem_load  = imem[imem_addr[7:2]];
            last_iaddr = imem_addr;

            // Data side
            d_active = dmem_ren || dmem_wen;
            if (d_active && (!d_prev_active || dhit)) begin
                d_wait = next_delay();
            end else if (d_wait != 0) begin
                d_wait--;
            end
            dhit = d_active && (d_wait == 0);
            if (dhit && dmem_wen) begin
                dmem[dmem_addr[7:2]] = dmem_store;
            end
            dmem_load     = dmem[dmem_addr[7:2]];
            d_prev_active = d_active;
        end
    end

endmodule

/* tb_core.sv */
// Testbench top for core_top; runs three programs against a reference interpreter and checks
`include "core_settings.svh"

module tb_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    logic             CLK;
    logic             nrst;
    logic [`XLEN-1:0] imem_addr;
    logic             imem_ren;
    logic [`XLEN-1:0] imem_load;
    logic             ihit;
    logic [`XLEN-1:0] dmem_addr;
    logic             dmem_ren;
    logic             dmem_wen;
    logic [`XLEN-1:0] dmem_store;
    logic [`XLEN-1:0] dmem_load;
    logic             dhit;
    logic             halt;

    instr_t           prog [$];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    logic [`XLEN-1:0] ref_mem [64];

    logic             prev_req;
    logic             prev_hit;
    logic             prev_wen;
    logic [`XLEN-1:0] prev_addr;
    logic [`XLEN-1:0] prev_store;

    core_top core_top_i (
        .CLK        (CLK),
        .nrst       (nrst),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_load  (imem_load),
        .ihit       (ihit),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_store (dmem_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .halt       (halt)
    );

    tb_mem_model mem_i (
        .CLK        (CLK),
        .nrst       (nrst),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_load  (imem_load),
        .ihit       (ihit),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_store (dmem_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic instr_t encode_reg_op(alu_op_t f, int rd, int rs1, int rs2);
        instr_t w;
        w = '0;
        w.r_fmt.opcode = OP_ALU;
        w.r_fmt.rd     = 5'(rd);
        w.r_fmt.rs1    = 5'(rs1);
        w.r_fmt.rs2    = 5'(rs2);
        w.r_fmt.funct  = f;
        return w;
    endfunction

    function automatic instr_t encode_imm_op(opcode_t op, int rd, int rs1, int imm);
        instr_t w;
        w = '0;
        w.i_fmt.opcode = op;
        w.i_fmt.rd     = 5'(rd);
        w.i_fmt.rs1    = 5'(rs1);
        w.i_fmt.imm    = 16'(imm);
        return w;
    endfunction

    // Data fill mixes every address bit
    function automatic logic [`XLEN-1:0] dmem_fill(int i);
        return (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    task automatic build_program(input int which);
        prog.delete();
        case (which)
            // Dependent ALU chain
            0: begin
                prog.push_back(encode_imm_op(OP_ADDI, 1, 0, 5));
                prog.push_back(encode_imm_op(OP_ADDI, 2, 1, 7));
                prog.push_back(encode_reg_op(ADD, 3, 1, 2));
                prog.push_back(encode_reg_op(SUB, 4, 3, 1));
                prog.push_back(encode_reg_op(AND, 5, 4, 2));
                prog.push_back(encode_reg_op(OR, 6, 5, 3));
                prog.push_back(encode_reg_op(XOR, 7, 6, 1));
                prog.push_back(encode_imm_op(OP_SW, 3, 0, 0));
                prog.push_back(encode_imm_op(OP_SW, 4, 0, 4));
                prog.push_back(encode_imm_op(OP_SW, 5, 0, 8));
                prog.push_back(encode_imm_op(OP_SW, 6, 0, 12));
                prog.push_back(encode_imm_op(OP_SW, 7, 0, 16));
                prog.push_back(encode_imm_op(OP_ADDI, 1, 1, -3));
                prog.push_back(encode_imm_op(OP_SW, 1, 0, 20));
            end
            // Taken and untaken branches, with a short backward loop
            1: begin
                prog.push_back(encode_imm_op(OP_ADDI, 1, 0, 3));
                prog.push_back(encode_imm_op(OP_ADDI, 2, 0, 3));
                prog.push_back(encode_imm_op(OP_BEQ, 1, 2, 3));
                prog.push_back(encode_imm_op(OP_SW, 1, 0, 32));
                prog.push_back(encode_imm_op(OP_SW, 2, 0, 36));
                prog.push_back(encode_imm_op(OP_BNE, 1, 2, 2));
                prog.push_back(encode_imm_op(OP_SW, 1, 0, 40));
                prog.push_back(encode_imm_op(OP_ADDI, 3, 0, 1));
                prog.push_back(encode_imm_op(OP_BNE, 3, 1, 3));
                prog.push_back(encode_imm_op(OP_SW, 3, 0, 44));
                prog.push_back(encode_imm_op(OP_HALT, 0, 0, 0));
                prog.push_back(encode_imm_op(OP_SW, 3, 0, 48));
                prog.push_back(encode_imm_op(OP_BEQ, 3, 1, 2));
                prog.push_back(encode_imm_op(OP_ADDI, 6, 0, 12));
                prog.push_back(encode_imm_op(OP_ADDI, 5, 5, 4));
                prog.push_back(encode_imm_op(OP_SW, 5, 5, 60));
                prog.push_back(encode_imm_op(OP_BNE, 5, 6, -2));
            end
            // Loads feeding dependent stores
            default: begin
                prog.push_back(encode_imm_op(OP_LW, 1, 0, 8));
                prog.push_back(encode_imm_op(OP_SW, 1, 0, 128));
                prog.push_back(encode_imm_op(OP_LW, 2, 0, 12));
                prog.push_back(encode_reg_op(ADD, 3, 1, 2));
                prog.push_back(encode_imm_op(OP_SW, 3, 0, 132));
                prog.push_back(encode_imm_op(OP_ADDI, 4, 0, 16));
                prog.push_back(encode_imm_op(OP_LW, 5, 4, 4));
                prog.push_back(encode_imm_op(OP_SW, 5, 4, 120));
                prog.push_back(encode_imm_op(OP_SW, 5, 4, 0));
                prog.push_back(encode_imm_op(OP_LW, 6, 4, 0));
                prog.push_back(encode_reg_op(XOR, 7, 6, 1));
                prog.push_back(encode_imm_op(OP_SW, 7, 0, 140));
            end
        endcase
        prog.push_back(encode_imm_op(OP_HALT, 0, 0, 0));
    endtask

    // Reference interpreter straight from the ISA rules
    task automatic interpret_program();
        logic [`XLEN-1:0] regs [32];
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] res;
        instr_t           w;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 2000; step++) begin
            w = (pc[31:2] < 32'(prog.size())) ? prog[pc[31:2]] : encode_imm_op(OP_HALT, 0, 0, 0);
            imm = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
            addr = regs[w.i_fmt.rs1] + imm;
            res = '0;
            if (w.i_fmt.opcode == OP_HALT) begin
                break;
            end
            case (w.i_fmt.opcode)
                OP_ALU: begin
                    case (w.r_fmt.funct)
                        ADD: res = regs[w.r_fmt.rs1] + regs[w.r_fmt.rs2];
                        SUB: res = regs[w.r_fmt.rs1] - regs[w.r_fmt.rs2];
                        AND: res = regs[w.r_fmt.rs1] & regs[w.r_fmt.rs2];
                        OR:  res = regs[w.r_fmt.rs1] | regs[w.r_fmt.rs2];
                        default: res = regs[w.r_fmt.rs1] ^ regs[w.r_fmt.rs2];
                    endcase
                    regs[w.r_fmt.rd] = res;
                end
                OP_ADDI: regs[w.i_fmt.rd] = addr;
                OP_LW:   regs[w.i_fmt.rd] = ref_mem[addr[7:2]];
                OP_SW: begin
                    ref_mem[addr[7:2]] = regs[w.i_fmt.rd];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[w.i_fmt.rd]);
                end
                default: begin
                end
            endcase
            regs[0] = '0;
            if ((w.i_fmt.opcode == OP_BEQ && regs[w.i_fmt.rd] == regs[w.i_fmt.rs1]) ||
                (w.i_fmt.opcode == OP_BNE && regs[w.i_fmt.rd] != regs[w.i_fmt.rs1])) begin
                pc = pc + (imm << 2);
            end else begin
                pc = pc + 4;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        #1 nrst = 1'b0;
        repeat (4) begin
            @(negedge CLK);
            assert (!dmem_ren && !dmem_wen && !halt) else
                stop_on_error("data request or halt active during reset");
        end
        @(posedge CLK);
        #1 nrst = 1'b1;
        @(negedge CLK);
        assert (!dmem_ren && !dmem_wen && !halt) else
            stop_on_error("data request or halt active right after reset");
        assert (imem_addr === `XLEN'(`RESET_PC)) else
            stop_on_error($sformatf("error t=%0t imem_addr expected %h got %h",
                                    $time, `XLEN'(`RESET_PC), imem_addr));
    endtask

    task automatic run_program(input int which);
        int limit;
        int cycles;
        build_program(which);
        // Slots past the program hold noise that must never be dispatched
        for (int i = 0; i < 64; i++) begin
            mem_i.imem[i] = ~dmem_fill(i);
            mem_i.dmem[i] = dmem_fill(i);
            ref_mem[i]    = dmem_fill(i);
        end
        foreach (prog[i]) begin
            mem_i.imem[i] = prog[i];
        end
        interpret_program();
        apply_reset();
        // Worst-case hit delay is 3, so 4 cycles per access
        limit = 40 * prog.size() * 4;
        cycles = 0;
        while (!halt) begin
            @(negedge CLK);
            cycles++;
            if (cycles > limit) begin
                stop_on_error($sformatf("timeout, core never halted in program %0d", which));
            end
        end
        repeat (20) @(negedge CLK);
        assert (exp_addr.size() == 0) else
            stop_on_error($sformatf("%0d expected stores never seen", exp_addr.size()));
        for (int i = 0; i < 64; i++) begin
            assert (mem_i.dmem[i] === ref_mem[i]) else
                stop_on_error($sformatf("error t=%0t dmem[%0d] expected %h got %h",
                                        $time, i, ref_mem[i], mem_i.dmem[i]));
        end
    endtask

    always @(negedge CLK) begin
        if (!nrst) begin
            prev_req = 1'b0;
        end else begin
            if (dmem_wen && dhit) begin
                assert (exp_addr.size() != 0) else
                    stop_on_error("store seen beyond the expected sequence");
                assert (dmem_addr === exp_addr[0]) else
                    stop_on_error($sformatf("error t=%0t dmem_addr expected %h got %h",
                                            $time, exp_addr[0], dmem_addr));
                assert (dmem_store === exp_data[0]) else
                    stop_on_error($sformatf("error t=%0t dmem_store expected %h got %h",
                                            $time, exp_data[0], dmem_store));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
            // Request must hold until its hit
            if (prev_req && !prev_hit) begin
                assert (dmem_addr === prev_addr) else
                    stop_on_error($sformatf("error t=%0t dmem_addr expected %h got %h",
                                            $time, prev_addr, dmem_addr));
                assert (dmem_wen === prev_wen) else
                    stop_on_error($sformatf("error t=%0t dmem_wen expected %b got %b",
                                            $time, prev_wen, dmem_wen));
                assert (!prev_wen || dmem_store === prev_store) else
                    stop_on_error($sformatf("error t=%0t dmem_store expected %h got %h",
                                            $time, prev_store, dmem_store));
            end
            if (halt) begin
                assert (!dmem_ren && !dmem_wen && !imem_ren) else
                    stop_on_error("memory request while halted");
            end
            prev_req   = dmem_ren || dmem_wen;
            prev_hit   = dhit;
            prev_wen   = dmem_wen;
            prev_addr  = dmem_addr;
            prev_store = dmem_store;
        end
    end

    halt_sticky: assert property (@(negedge CLK) disable iff (!nrst) halt |=> halt)
        else stop_on_error("halt dropped before reset");

    initial begin
        nrst     = 1'b0;
        prev_req = 1'b0;
        for (int p = 0; p < 3; p++) begin
            run_program(p);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
core_pkg.sv
fetch_unit.sv
reg_file.sv
dispatch_unit.sv
execute_unit.sv
mem_writeback_unit.sv
core_top.sv
tb_mem_model.sv
tb_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f sources.f -o tb_core_sim
./obj_dir/tb_core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
